// ==== turtleOperandUnit.f ====
rvArchPkg.sv
rvChannelPkg.sv
prioMux.sv
pcGen.sv
fwdMux.sv
regFile.sv
turtleOperandUnit.sv
tbChecker.sv
tbTurtleOperandUnit.sv

// ==== Makefile ====
# Verilator build and run for the operand unit testbench

VERILATOR ?= verilator
TOP       ?= tbTurtleOperandUnit
FLIST     ?= turtleOperandUnit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Status comes from the pass line in the output
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tbTurtleOperandUnit.sv ====
`timescale 1ns/1ps

module tbTurtleOperandUnit import rvArchPkg::*; import rvChannelPkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int TEST_NUM     = 5;
  localparam int TEST_CYCLES  = 200;
  // Reset, all tests, and a small margin for the summary
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_NUM * TEST_CYCLES + 20) * CLK_PERIOD;

  logic                         clk;
  logic                         arstN;
  logic                         stall;
  pcSetChanT [PC_SET_NUM-1:0]   pcSet;
  logic      [STEP_W-1:0]       step;
  xlenT                         pc;
  xlenT                         nxtPc;
  rfWrChanT                     rfWr;
  rfWrChanT  [FWD_PORT_NUM-1:0] fwdBus;
  regIdxT    [RD_PORT_NUM-1:0]  rs;
  xlenT      [RD_PORT_NUM-1:0]  rsDat;
  logic      [RD_PORT_NUM-1:0]  hazard;

  int     seed;
  int     testNum;
  regIdxT lastWrRd;
  int     testsRun;
  int     testsBad;
  int     checkTotal;
  int     errTotal;

  always #(CLK_PERIOD / 2) clk = ~clk;

  turtleOperandUnit uut (
    .clk    (clk),
    .arstN  (arstN),
    .stall  (stall),
    .pcSet  (pcSet),
    .step   (step),
    .pc     (pc),
    .nxtPc  (nxtPc),
    .rfWr   (rfWr),
    .fwdBus (fwdBus),
    .rs     (rs),
    .rsDat  (rsDat),
    .hazard (hazard)
  );

  tbChecker uChk (
    .clk        (clk),
    .arstN      (arstN),
    .stall      (stall),
    .pcSet      (pcSet),
    .step       (step),
    .pc         (pc),
    .nxtPc      (nxtPc),
    .rfWr       (rfWr),
    .fwdBus     (fwdBus),
    .rs         (rs),
    .rsDat      (rsDat),
    .hazard     (hazard),
    .testNum    (testNum),
    .testsRun   (testsRun),
    .testsBad   (testsBad),
    .checkTotal (checkTotal),
    .errTotal   (errTotal)
  );

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Stalls and redirects only in the fetch test
  task automatic driveFetch(input int mode);
    pcSetChanT [PC_SET_NUM-1:0] req;
    logic      [STEP_W-1:0]     inc;
    req = '0;
    inc = STEP_W'($random(seed));
    // Nonzero step shows the post-reset hold
    if (inc == '0) begin
      inc = STEP_W'(4);
    end
    if (mode == 2) begin
      for (int i = 0; i < PC_SET_NUM; i++) begin
        req[i].en    = (($random(seed) & 3) == 0);
        req[i].tgtPc = xlenT'($random(seed)) & ~xlenT'(1);
      end
    end
    stall <= (mode == 2) && (($random(seed) & 3) == 0);
    pcSet <= req;
    step  <= inc;
  endtask

  task automatic driveOperands(input int mode);
    rfWrChanT                     wr;
    rfWrChanT  [FWD_PORT_NUM-1:0] bus;
    regIdxT    [RD_PORT_NUM-1:0]  idx;
    int                           pick;
    wr.vld = (($random(seed) & 3) != 0);
    wr.rd  = regIdxT'($random(seed));
    wr.dat = xlenT'($random(seed));
    bus    = '0;
    for (int p = 0; p < RD_PORT_NUM; p++) begin
      idx[p] = regIdxT'($random(seed));
    end
    if (mode == 3) begin
      // Read back last cycle's write
      idx[0] = lastWrRd;
      if (($random(seed) & 1) != 0) begin
        idx[1] = lastWrRd;
      end
    end else if (mode >= 4) begin
      for (int b = 0; b < FWD_PORT_NUM; b++) begin
        bus[b].vld = (mode == 4) ? 1'b1 : (($random(seed) & 1) != 0);
        bus[b].rd  = regIdxT'($random(seed));
        bus[b].dat = xlenT'($random(seed));
      end
      // Same register on both buses
      if (($random(seed) & 3) == 0) begin
        bus[1].rd = bus[0].rd;
      end
      // Mostly read what a bus produces
      for (int p = 0; p < RD_PORT_NUM; p++) begin
        pick = $random(seed) & 3;
        if (pick < FWD_PORT_NUM) begin
          idx[p] = bus[pick].rd;
        end
      end
    end
    lastWrRd = wr.rd;
    rfWr   <= wr;
    fwdBus <= bus;
    rs     <= idx;
  endtask

  task automatic runTest(input int id);
    for (int c = 0; c < TEST_CYCLES; c++) begin
      testNum <= id;
      driveFetch(id);
      driveOperands(id);
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    seed     = 22;
    clk      = 1'b0;
    arstN    = 1'b0;
    stall    = 1'b0;
    pcSet    = '0;
    step     = '0;
    rfWr     = '0;
    fwdBus   = '0;
    rs       = '0;
    testNum  = 0;
    lastWrRd = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    // First test inputs go out with the release
    arstN <= 1'b1;
    for (int t = 1; t <= TEST_NUM; t++) begin
      runTest(t);
    end
    testNum <= 0;
    @(negedge clk);
    #1;
    $display("summary: %0d of %0d tests run, %0d with mismatches, %0d checks, %0d mismatches",
             testsRun, TEST_NUM, testsBad, checkTotal, errTotal);
    if (errTotal == 0 && testsBad == 0 && testsRun == TEST_NUM) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run still going after %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

endmodule : tbTurtleOperandUnit

// ==== tbChecker.sv ====
`timescale 1ns/1ps

module tbChecker import rvArchPkg::*; import rvChannelPkg::*; (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         stall,
  input  pcSetChanT [PC_SET_NUM-1:0]   pcSet,
  input  logic      [STEP_W-1:0]       step,
  input  xlenT                         pc,
  input  xlenT                         nxtPc,
  input  rfWrChanT                     rfWr,
  input  rfWrChanT  [FWD_PORT_NUM-1:0] fwdBus,
  input  regIdxT    [RD_PORT_NUM-1:0]  rs,
  input  xlenT      [RD_PORT_NUM-1:0]  rsDat,
  input  logic      [RD_PORT_NUM-1:0]  hazard,
  // Zero between tests and after the last one
  input  int                           testNum,
  output int                           testsRun,
  output int                           testsBad,
  output int                           checkTotal,
  output int                           errTotal
);

  // Reference state
  xlenT mPc;
  logic mRunning;
  xlenT mRegs [REG_NUM];

  // Per-test bookkeeping
  int   prevTest;
  int   testChecks;
  int   testErrs;

  initial begin
    testsRun   = 0;
    testsBad   = 0;
    checkTotal = 0;
    errTotal   = 0;
    prevTest   = 0;
    testChecks = 0;
    testErrs   = 0;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // First enabled channel wins, else sequential
  function automatic xlenT expNxtPc();
    xlenT tgt;
    logic hit;
    tgt = mPc + xlenT'(step);
    hit = 1'b0;
    for (int i = 0; i < PC_SET_NUM; i++) begin
      if (!hit && pcSet[i].en) begin
        hit = 1'b1;
        tgt = pcSet[i].tgtPc;
      end
    end
    // Held at the boot vector until running
    if (!mRunning) begin
      tgt = mPc;
    end
    return tgt;
  endfunction

  // Lowest matching bus overrides the array
  function automatic void expRead(input regIdxT idx, output xlenT dat, output logic haz);
    logic found;
    found = 1'b0;
    dat   = mRegs[idx];
    haz   = 1'b0;
    if (idx != '0) begin
      for (int b = 0; b < FWD_PORT_NUM; b++) begin
        if (!found && fwdBus[b].rd == idx) begin
          found = 1'b1;
          dat   = fwdBus[b].dat;
          haz   = !fwdBus[b].vld;
        end
      end
    end else begin
      dat = '0;
    end
  endfunction

  // Inputs are stable here, they change on the falling edge
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mPc      <= START_ADDR;
      mRunning <= 1'b0;
      for (int r = 0; r < REG_NUM; r++) begin
        mRegs[r] <= '0;
      end
    end else begin
      if (!stall) begin
        mPc <= expNxtPc();
      end
      mRunning <= 1'b1;
      if (rfWr.vld && rfWr.rd != '0) begin
        mRegs[rfWr.rd] <= rfWr.dat;
      end
    end
  end

  ////////////////////////////////////////
  // Comparison and reporting
  ////////////////////////////////////////

  function automatic string testName(input int id);
    case (id)
      1:       return "after reset";
      2:       return "stall and redirect";
      3:       return "register write and read";
      4:       return "forwarding";
      5:       return "hazard";
      default: return "unknown";
    endcase
  endfunction

  task automatic checkWord(input string name, input xlenT exp, input xlenT act);
    testChecks++;
    checkTotal++;
    if (exp !== act) begin
      testErrs++;
      errTotal++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    testChecks++;
    checkTotal++;
    if (exp !== act) begin
      testErrs++;
      errTotal++;
      $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // One line per finished test
  task automatic closeTest();
    testsRun++;
    if (testChecks == 0) begin
      testsBad++;
      $display("test %0d %s ran no checks at all", prevTest, testName(prevTest));
    end else begin
      if (testErrs != 0) begin
        testsBad++;
      end
      $display("test %0d %s: %0d checks, %0d mismatches", prevTest,
               testName(prevTest), testChecks, testErrs);
    end
    testChecks = 0;
    testErrs   = 0;
  endtask

  // Sampled before the stimulus updates land
  always @(negedge clk) begin : compare
    xlenT expDat;
    logic expHaz;
    if (prevTest != 0 && testNum != prevTest) begin
      closeTest();
    end
    if (arstN && testNum != 0) begin
      checkWord("pc", mPc, pc);
      checkWord("nxtPc", expNxtPc(), nxtPc);
      for (int p = 0; p < RD_PORT_NUM; p++) begin
        expRead(rs[p], expDat, expHaz);
        checkWord($sformatf("rsDat[%0d]", p), expDat, rsDat[p]);
        checkBit($sformatf("hazard[%0d]", p), expHaz, hazard[p]);
      end
    end
    prevTest = testNum;
  end

endmodule : tbChecker

// ==== turtleOperandUnit.sv ====
`timescale 1ns/1ps

module turtleOperandUnit import rvArchPkg::*; import rvChannelPkg::*; (
  input  logic                         clk,
  input  logic                         arstN,
  // Fetch side
  input  logic                         stall,
  input  pcSetChanT [PC_SET_NUM-1:0]   pcSet,
  input  logic      [STEP_W-1:0]       step,
  output xlenT                         pc,
  output xlenT                         nxtPc,
  // Operand side
  input  rfWrChanT                     rfWr,
  input  rfWrChanT  [FWD_PORT_NUM-1:0] fwdBus,
  input  regIdxT    [RD_PORT_NUM-1:0]  rs,
  output xlenT      [RD_PORT_NUM-1:0]  rsDat,
  output logic      [RD_PORT_NUM-1:0]  hazard
);

  ////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////

  // Redirects come from execute and later
  pcGen uPcGen (
    .clk    (clk),
    .arstN  (arstN),
    .stall  (stall),
    .pcSet  (pcSet),
    .step   (step),
    .pc     (pc),
    .nxtPc  (nxtPc)
  );

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  // Hazard is advisory
  // Stall is decided by the pipeline control outside
  regFile uRegFile (
    .clk    (clk),
    .arstN  (arstN),
    .rfWr   (rfWr),
    .fwdBus (fwdBus),
    .rs     (rs),
    .rsDat  (rsDat),
    .hazard (hazard)
  );

endmodule : turtleOperandUnit

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile import rvArchPkg::*; import rvChannelPkg::*; (
  input  logic                         clk,
  input  logic                         arstN,
  input  rfWrChanT                     rfWr,
  input  rfWrChanT [FWD_PORT_NUM-1:0]  fwdBus,
  input  regIdxT   [RD_PORT_NUM-1:0]   rs,
  output xlenT     [RD_PORT_NUM-1:0]   rsDat,
  output logic     [RD_PORT_NUM-1:0]   hazard
);

  // Entry 0 is a constant
  xlenT               regArr [REG_NUM];
  logic [REG_NUM-1:0] wrOh;

  ////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////

  // Decoded write enable, only when the channel is valid
  assign wrOh = rfWr.vld ? (REG_NUM'(1) << rfWr.rd) : '0;

  assign regArr[0] = '0;

  // x1..x31, wrOh[0] falls on the constant entry
  for (genvar r = 1; r < REG_NUM; r++) begin : genReg
    always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
        regArr[r] <= '0;
      end else if (wrOh[r]) begin
        regArr[r] <= rfWr.dat;
      end
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  // Same-cycle write is not bypassed here
  // Later stages present it on a forwarding bus
  for (genvar p = 0; p < RD_PORT_NUM; p++) begin : genRd
    xlenT rfDat;

    assign rfDat = regArr[rs[p]];

    fwdMux uFwdMux (
      .rs     (rs[p]),
      .rfDat  (rfDat),
      .fwdBus (fwdBus),
      .dat    (rsDat[p]),
      .hazard (hazard[p])
    );

    // Whole read path, array plus bypass, keeps x0 at zero
    x0ReadA: assert property (@(posedge clk) disable iff (!arstN)
      rs[p] == '0 |-> rsDat[p] == '0 && !hazard[p])
      else $error("read port %0d returned nonzero for x0", p);
  end

endmodule : regFile

// ==== fwdMux.sv ====
`timescale 1ns/1ps

module fwdMux import rvArchPkg::*; import rvChannelPkg::*; (
  input  regIdxT                       rs,
  input  xlenT                         rfDat,
  input  rfWrChanT [FWD_PORT_NUM-1:0]  fwdBus,
  output xlenT                         dat,
  output logic                         hazard
);

  // x0 never forwards
  logic                    rsVld;
  logic [FWD_PORT_NUM-1:0] cand;
  logic [FWD_PORT_NUM-1:0] candOh;
  logic [FWD_PORT_NUM-1:0] busVld;
  xlenT                    busDat [FWD_PORT_NUM];
  xlenT                    baseDat;
  logic                    fwdHit;

  assign rsVld = |rs;

  // Bus matches when it produces the register we read
  always_comb begin
    for (int i = 0; i < FWD_PORT_NUM; i++) begin
      cand[i]   = rsVld & (fwdBus[i].rd == rs);
      busVld[i] = fwdBus[i].vld;
      busDat[i] = fwdBus[i].dat;
    end
  end

  // Isolate lowest candidate, same choice as the mux
  assign candOh = cand & (~cand + 1'b1);

  // Array value unless a bus claims the register
  assign baseDat = rsVld ? rfDat : '0;

  prioMux #(
    .itemT (xlenT),
    .N     (FWD_PORT_NUM)
  ) uFwdSel (
    .sel   (cand),
    .items (busDat),
    .dflt  (baseDat),
    .out   (dat),
    .any   (fwdHit)
  );

  // Winning producer has no data yet
  assign hazard = fwdHit & |(candOh & ~busVld);

  // x0 reads are always safe
  always_comb begin
    if (!rsVld) begin
      x0NoHazA: assert (!hazard && dat == '0)
        else $error("fwdMux flagged x0 or returned nonzero data");
    end
  end

endmodule : fwdMux

// ==== pcGen.sv ====
`timescale 1ns/1ps

module pcGen import rvArchPkg::*; import rvChannelPkg::*; (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         stall,
  input  pcSetChanT [PC_SET_NUM-1:0]   pcSet,
  input  logic      [STEP_W-1:0]       step,
  output xlenT                         pc,
  output xlenT                         nxtPc
);

  // Low for exactly one edge after reset
  logic                  running;
  logic [PC_SET_NUM-1:0] setEn;
  xlenT                  tgtPc [PC_SET_NUM];
  xlenT                  stepPc;

  ////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////

  // Redirects are masked until the core runs
  always_comb begin
    for (int i = 0; i < PC_SET_NUM; i++) begin
      setEn[i] = pcSet[i].en & running;
      tgtPc[i] = pcSet[i].tgtPc;
    end
  end

  // Zero step while held so the boot vector repeats
  assign stepPc = pc + (running ? xlenT'(step) : '0);

  // Sequential address is the fallback
  prioMux #(
    .itemT (xlenT),
    .N     (PC_SET_NUM)
  ) uSetMux (
    .sel   (setEn),
    .items (tgtPc),
    .dflt  (stepPc),
    .out   (nxtPc),
    .any   ()
  );

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  // Stall does not delay the start
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      running <= 1'b0;
    end else begin
      running <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= START_ADDR;
    end else if (!stall) begin
      pc <= nxtPc;
    end
  end

  // Boot vector survives the first edge out of reset
  startHoldA: assert property (@(posedge clk) disable iff (!arstN)
    !running |=> pc == START_ADDR)
    else $error("pc left the start address too early");

endmodule : pcGen

// ==== prioMux.sv ====
`timescale 1ns/1ps

module prioMux import rvArchPkg::*; #(
  parameter type itemT = xlenT,
  parameter int  N     = FWD_PORT_NUM
) (
  input  logic [N-1:0] sel,
  input  itemT         items [N],
  input  itemT         dflt,
  output itemT         out,
  output logic         any
);

  // Lowest set bit wins
  // Walk from the top so the last hit is the lowest index
  always_comb begin
    out = dflt;
    for (int i = N - 1; i >= 0; i--) begin
      if (sel[i]) begin
        out = items[i];
      end
    end
    any = |sel;
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Nothing selected means fall back to the default item
  always_comb begin
    if (!any) begin
      dfltSelA: assert (out == dflt)
        else $error("prioMux output differs from default with empty select");
    end
  end

endmodule : prioMux

// ==== rvChannelPkg.sv ====
package rvChannelPkg;

  // Channel fields are built from the scalar types
  import rvArchPkg::*;

  ////////////////////////////////////////
  // Fetch redirect
  ////////////////////////////////////////

  // One redirect request from a later stage
  // Branch, jump or trap all look the same here
  typedef struct packed {
    // Request this cycle
    logic en;
    // Address to fetch from
    xlenT tgtPc;
  } pcSetChanT;

  ////////////////////////////////////////
  // Register write and bypass
  ////////////////////////////////////////

  // Shared by the write port and every forwarding bus
  // On a forwarding bus rd marks the register in flight
  // vld low there means the value is not computed yet
  typedef struct packed {
    // Data is present
    logic   vld;
    // Destination register
    regIdxT rd;
    // Result word
    xlenT   dat;
  } rfWrChanT;

  // Field widths for quick reference
  // pcSetChanT is XLEN + 1 bits
  // rfWrChanT is XLEN + REG_IDX_W + 1 bits

endpackage : rvChannelPkg

// ==== rvArchPkg.sv ====
package rvArchPkg;

  ////////////////////////////////////////
  // Datapath geometry
  ////////////////////////////////////////

  // RV32 only
  localparam int XLEN = 32;

  // Integer register file, x0 included
  localparam int REG_NUM   = 32;
  localparam int REG_IDX_W = $clog2(REG_NUM);

  // Two source operands per instruction
  localparam int RD_PORT_NUM = 2;

  // Bypass buses from later stages
  // Bus 0 is the youngest producer and wins
  localparam int FWD_PORT_NUM = 2;

  ////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////

  // Redirect sources, lowest index first
  localparam int PC_SET_NUM = 3;

  // Boot vector
  localparam logic [XLEN-1:0] START_ADDR = 32'h0000_0200;

  // Step is small, enough for 2 or 4 byte instructions
  localparam int STEP_W = 4;

  // Scalar types
  typedef logic [XLEN-1:0]      xlenT;
  typedef logic [REG_IDX_W-1:0] regIdxT;

endpackage : rvArchPkg
